/* common/periph_pkg.sv */
// ----------------------------------------------------------------------
// Peripheral package
// Host bus widths, the region address map, the unit select struct and
// the reset values shared by the peripheral units
// ----------------------------------------------------------------------
package periph_pkg;

    // Host bus widths
    localparam int addr_w = 24;
    localparam int data_w = 32;
    localparam int strb_w = 4;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;

    // Region field occupies address bits 19..16
    localparam int region_lsb = 16;
    localparam int region_w = 4;

    localparam logic [region_w-1:0] region_status = 4'd0;
    localparam logic [region_w-1:0] region_dsp = 4'd1;
    localparam logic [region_w-1:0] region_pad = 4'd2;
    localparam logic [region_w-1:0] region_flash = 4'd3;

    // Operand B when set, operand A when clear
    localparam int dsp_b_bit = 2;

    // Red LED on, blue LED off
    localparam logic [1:0] status_reset_value = 2'b01;

    // Quad flash data lines
    localparam int flash_pins = 4;

    // One bit per unit plus the access direction
    typedef struct packed {
        logic status;
        logic dsp;
        logic pad;
        logic flash;
        logic write;
        logic read;
    } periph_sel_t;

endpackage

/* common/periph_bus_if.sv */
// ----------------------------------------------------------------------
// Peripheral host bus
// Request side of the host bus, driven by the top level and observed
// by the decoder and the register units
// ----------------------------------------------------------------------
interface periph_bus_if;
    import periph_pkg::*;

    logic valid;
    addr_t address;
    data_t write_data;
    logic [strb_w-1:0] wstrb;

    // Top level drives the request
    modport host (
        output valid,
        output address,
        output write_data,
        output wstrb
    );

    // Decoder and units only observe it
    modport unit (
        input valid,
        input address,
        input write_data,
        input wstrb
    );

endinterface

/* hdl/periph_decoder.sv */
// ----------------------------------------------------------------------
// Peripheral address decoder
// Maps the region field of a valid access onto one unit select and
// marks the access as a read or a write
// ----------------------------------------------------------------------
module periph_decoder (
    input logic vdp_clk,
    input logic vdp_reset,
    periph_bus_if.unit bus,
    output periph_pkg::periph_sel_t sel
);
    import periph_pkg::*;

    logic [region_w-1:0] region;
    logic is_write;

    assign region = bus.address[region_lsb +: region_w];

    // Any nonzero strobe makes the access a write
    assign is_write = |bus.wstrb;

    always_comb begin
        sel = '0;

        // Direction is flagged even for unmapped regions so they still get ready
        sel.write = bus.valid && is_write;
        sel.read = bus.valid && !is_write;

        sel.status = bus.valid && (region == region_status);
        sel.dsp = bus.valid && (region == region_dsp);
        sel.pad = bus.valid && (region == region_pad);
        sel.flash = bus.valid && (region == region_flash);
    end

    // At most one unit may see an access
    unit_select_onehot: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        $onehot0({sel.status, sel.dsp, sel.pad, sel.flash})
    );

endmodule

/* hdl/dsp_mult.sv */
// ----------------------------------------------------------------------
// DSP multiplier
// Two operand registers written from the host and a registered signed
// product that follows them one cycle later
// ----------------------------------------------------------------------
module dsp_mult #(
    parameter int mult_w = 16
) (
    input logic vdp_clk,
    periph_bus_if.unit bus,
    input periph_pkg::periph_sel_t sel,
    output periph_pkg::data_t product
);
    import periph_pkg::*;

    logic signed [mult_w-1:0] op_a;
    logic signed [mult_w-1:0] op_b;
    logic signed [2*mult_w-1:0] product_full;
    logic dsp_write;

    assign dsp_write = sel.dsp && sel.write;

    // Separate enables keep each operand a plain enabled register
    always_ff @(posedge vdp_clk) begin
        if (dsp_write && !bus.address[dsp_b_bit]) begin
            op_a <= bus.write_data[mult_w-1:0];
        end

        if (dsp_write && bus.address[dsp_b_bit]) begin
            op_b <= bus.write_data[mult_w-1:0];
        end
    end

    assign product_full = op_a * op_b;

    // Signed result, refreshed every cycle
    always_ff @(posedge vdp_clk) begin
        product <= data_t'(product_full);
    end

endmodule

/* hdl/pad_reader.sv */
// ----------------------------------------------------------------------
// Gamepad reader
// Latch and clock control bits from the host and a button shift
// register that is read out one bit at a time
// ----------------------------------------------------------------------
module pad_reader #(
    parameter int pad_bits = 16
) (
    input logic vdp_clk,
    input logic vdp_reset,
    periph_bus_if.unit bus,
    input periph_pkg::periph_sel_t sel,
    input logic btn_1,
    input logic btn_2,
    input logic btn_3,
    output logic pad_bit
);
    logic pad_latch;
    logic pad_clk;
    logic pad_clk_r;
    logic [pad_bits-1:0] pad_state;

    // Control bits, bit 0 latch and bit 1 clock
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch <= 1'b0;
            pad_clk <= 1'b0;
            pad_clk_r <= 1'b0;
        end else begin
            if (sel.pad && sel.write) begin
                pad_latch <= bus.write_data[0];
                pad_clk <= bus.write_data[1];
            end
            pad_clk_r <= pad_clk;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (pad_latch) begin
            // Left, right and B buttons
            pad_state <= {btn_1, btn_3, {(pad_bits-3){1'b0}}, btn_2};
        end

        // Shift on the rising edge of the control clock
        if (pad_clk && !pad_clk_r) begin
            pad_state <= {1'b0, pad_state[pad_bits-1:1]};
        end
    end

    assign pad_bit = pad_state[0];

    // Software must not latch and clock in the same write
    latch_clock_exclusive: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        !(pad_latch && pad_clk)
    );

endmodule

/* hdl/io_ctrl_regs.sv */
// ----------------------------------------------------------------------
// Status and flash control registers
// LED status register, bit-banged flash pin control and the sampled
// flash data inputs
// ----------------------------------------------------------------------
module io_ctrl_regs (
    input logic vdp_clk,
    input logic vdp_reset,
    periph_bus_if.unit bus,
    input periph_pkg::periph_sel_t sel,
    input logic [periph_pkg::flash_pins-1:0] flash_io_in,
    output logic led_r,
    output logic led_b,
    output logic flash_clk,
    output logic flash_csn,
    output logic [periph_pkg::flash_pins-1:0] flash_io_out,
    output logic [periph_pkg::flash_pins-1:0] flash_io_oe,
    output logic [periph_pkg::flash_pins-1:0] flash_sample
);
    import periph_pkg::*;

    logic [1:0] status;
    logic flash_active;
    logic flash_clk_r;
    logic flash_csn_r;
    logic [flash_pins-1:0] flash_out_r;
    logic [flash_pins-1:0] flash_oe_r;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= status_reset_value;
        end else if (sel.status && sel.write) begin
            status <= bus.write_data[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            flash_active <= 1'b0;
            flash_clk_r <= 1'b0;
            flash_csn_r <= 1'b1;
            flash_oe_r <= '0;
        end else if (sel.flash && sel.write) begin
            flash_active <= bus.write_data[15];
            flash_clk_r <= bus.write_data[8];
            flash_csn_r <= bus.write_data[9];
            flash_oe_r <= bus.write_data[7:4];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (sel.flash && sel.write) begin
            flash_out_r <= bus.write_data[3:0];
        end
    end

    // Idle levels unless software has taken the pins
    assign flash_csn = flash_active ? flash_csn_r : 1'b1;
    assign flash_clk = flash_active ? flash_clk_r : 1'b0;
    assign flash_io_oe = flash_active ? flash_oe_r : '0;
    assign flash_io_out = flash_active ? flash_out_r : '0;

    // Sampled every cycle for read-back
    always_ff @(posedge vdp_clk) begin
        flash_sample <= flash_io_in;
    end

endmodule

/* hdl/periph_readback.sv */
// ----------------------------------------------------------------------
// Peripheral read-back
// Registers the selected read data and answers each access with a
// single ready pulse
// ----------------------------------------------------------------------
module periph_readback (
    input logic vdp_clk,
    input logic vdp_reset,
    input periph_pkg::periph_sel_t sel,
    input periph_pkg::data_t product,
    input logic pad_bit,
    input logic [periph_pkg::flash_pins-1:0] flash_sample,
    output logic cpu_mem_ready,
    output periph_pkg::data_t cpu_read_data
);
    import periph_pkg::*;

    logic access;

    assign access = sel.read || sel.write;

    // Unmapped and status reads return zero
    always_ff @(posedge vdp_clk) begin
        if (sel.read && sel.dsp) begin
            cpu_read_data <= product;
        end else if (sel.read && sel.pad) begin
            cpu_read_data <= {{(data_w-1){1'b0}}, pad_bit};
        end else if (sel.read && sel.flash) begin
            cpu_read_data <= {{(data_w-flash_pins){1'b0}}, flash_sample};
        end else begin
            cpu_read_data <= '0;
        end
    end

    // Requester drops valid after seeing ready, so one pulse per access
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            cpu_mem_ready <= 1'b0;
        end else begin
            cpu_mem_ready <= access && !cpu_mem_ready;
        end
    end

    ready_single_pulse: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
        cpu_mem_ready |=> !cpu_mem_ready
    );

endmodule

/* hdl/periph_top.sv */
// ----------------------------------------------------------------------
// Peripheral top level
// Host bus decode, multiplier, gamepad, status and flash registers
// and the read-back stage
// ----------------------------------------------------------------------
module periph_top #(
    parameter int mult_w = 16,
    parameter int pad_bits = 16
) (
    input logic vdp_clk,
    input logic vdp_reset,
    input logic cpu_mem_valid,
    input periph_pkg::addr_t cpu_address,
    input periph_pkg::data_t cpu_write_data,
    input logic [periph_pkg::strb_w-1:0] cpu_wstrb,
    output logic cpu_mem_ready,
    output periph_pkg::data_t cpu_read_data,
    input logic btn_1,
    input logic btn_2,
    input logic btn_3,
    output logic led_r,
    output logic led_b,
    output logic flash_clk,
    output logic flash_csn,
    output logic [periph_pkg::flash_pins-1:0] flash_io_out,
    output logic [periph_pkg::flash_pins-1:0] flash_io_oe,
    input logic [periph_pkg::flash_pins-1:0] flash_io_in
);
    import periph_pkg::*;

    periph_sel_t sel;
    data_t product;
    logic pad_bit;
    logic [flash_pins-1:0] flash_sample;

    periph_bus_if bus ();

    // Host request onto the internal bus
    assign bus.valid = cpu_mem_valid;
    assign bus.address = cpu_address;
    assign bus.write_data = cpu_write_data;
    assign bus.wstrb = cpu_wstrb;

    periph_decoder decoder_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.unit),
        .sel(sel)
    );

    dsp_mult #(
        .mult_w(mult_w)
    ) dsp_mult_i (
        .vdp_clk(vdp_clk),
        .bus(bus.unit),
        .sel(sel),
        .product(product)
    );

    pad_reader #(
        .pad_bits(pad_bits)
    ) pad_reader_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.unit),
        .sel(sel),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .pad_bit(pad_bit)
    );

    io_ctrl_regs io_ctrl_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.unit),
        .sel(sel),
        .flash_io_in(flash_io_in),
        .led_r(led_r),
        .led_b(led_b),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_io_out(flash_io_out),
        .flash_io_oe(flash_io_oe),
        .flash_sample(flash_sample)
    );

    periph_readback readback_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .sel(sel),
        .product(product),
        .pad_bit(pad_bit),
        .flash_sample(flash_sample),
        .cpu_mem_ready(cpu_mem_ready),
        .cpu_read_data(cpu_read_data)
    );

endmodule

/* verif/periph_tb.sv */
// ----------------------------------------------------------------------
// Peripheral testbench
// Replays the bus trace against the peripheral top level and checks
// read data, LED and flash pins and the ready handshake
// ----------------------------------------------------------------------
module periph_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic vdp_clk;
    logic vdp_reset;
    logic cpu_mem_valid;
    logic [23:0] cpu_address;
    logic [31:0] cpu_write_data;
    logic [3:0] cpu_wstrb;
    logic cpu_mem_ready;
    logic [31:0] cpu_read_data;
    logic btn_1;
    logic btn_2;
    logic btn_3;
    logic led_r;
    logic led_b;
    logic flash_clk;
    logic flash_csn;
    logic [3:0] flash_io_out;
    logic [3:0] flash_io_oe;
    logic [3:0] flash_io_in;

    // Trace columns, one entry per line
    string name_q[$];
    string op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] btn_q[$];
    logic [31:0] fin_q[$];
    logic [31:0] exp_q[$];

    logic trace_ok = 1'b0;
    logic ready_prev = 1'b0;
    int cycle_limit = 0;
    int cycles = 0;
    int pass_count = 0;
    int fail_count = 0;
    int other_errors = 0;

    periph_top #(
        .mult_w(16),
        .pad_bits(16)
    ) dut_i (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .cpu_mem_valid(cpu_mem_valid),
        .cpu_address(cpu_address),
        .cpu_write_data(cpu_write_data),
        .cpu_wstrb(cpu_wstrb),
        .cpu_mem_ready(cpu_mem_ready),
        .cpu_read_data(cpu_read_data),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .led_r(led_r),
        .led_b(led_b),
        .flash_clk(flash_clk),
        .flash_csn(flash_csn),
        .flash_io_out(flash_io_out),
        .flash_io_oe(flash_io_oe),
        .flash_io_in(flash_io_in)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #2 vdp_clk = ~vdp_clk;
    end

    // LED and flash pins packed as in the trace
    function automatic logic [31:0] pins_word();
        return {20'd0, led_r, led_b, flash_csn, flash_clk, flash_io_oe, flash_io_out};
    endfunction

    task automatic load_trace();
        int fd;
        int n;
        string line;
        string name;
        string op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] btn;
        logic [31:0] fin;
        logic [31:0] exp_val;
        fd = $fopen("verif/periph_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file verif/periph_trace.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, data, btn, fin, exp_val);
            if (n != 7) begin
                $display("Trace line cannot be parsed: %s", line);
                other_errors++;
                continue;
            end
            name_q.push_back(name);
            op_q.push_back(op);
            addr_q.push_back(addr);
            data_q.push_back(data);
            btn_q.push_back(btn);
            fin_q.push_back(fin);
            exp_q.push_back(exp_val);
        end
        $fclose(fd);
        trace_ok = (name_q.size() > 0);
        if (!trace_ok) begin
            $display("The trace file holds no operations");
            other_errors++;
        end
    endtask

    // One access, held through the rising edge that shows ready,
    // then valid drops for a cycle
    task automatic bus_access(
        input logic [31:0] addr,
        input logic [31:0] data,
        input logic is_write,
        output logic [31:0] rdata,
        output int waits
    );
        waits = 0;
        cpu_mem_valid = 1'b1;
        cpu_address = addr[23:0];
        cpu_write_data = data;
        cpu_wstrb = is_write ? 4'hf : 4'h0;
        do begin
            @(negedge vdp_clk);
            waits++;
        end while (cpu_mem_ready !== 1'b1);
        rdata = cpu_read_data;
        // Requester sees ready at the next rising edge
        @(negedge vdp_clk);
        cpu_mem_valid = 1'b0;
        cpu_wstrb = 4'h0;
        @(negedge vdp_clk);
    endtask

    task automatic run_test(input int i);
        logic [31:0] got;
        int waits;
        logic passed;
        passed = 1'b1;
        got = '0;
        waits = 1;
        // Buttons and flash inputs settle one cycle ahead of the access
        {btn_3, btn_2, btn_1} = btn_q[i][2:0];
        flash_io_in = fin_q[i][3:0];
        @(negedge vdp_clk);
        if (op_q[i] == "pins") begin
            got = pins_word();
        end else if (op_q[i] == "write" || op_q[i] == "read") begin
            bus_access(addr_q[i], data_q[i], op_q[i] == "write", got, waits);
        end else begin
            $display("Test %s has an unknown operation %s", name_q[i], op_q[i]);
            passed = 1'b0;
        end
        if (waits != 1) begin
            $display("Test %s got ready %0d cycles after the request instead of 1",
                name_q[i], waits);
            passed = 1'b0;
        end
        if ((op_q[i] == "pins" || op_q[i] == "read") && got !== exp_q[i]) begin
            $display("Mismatch in %s: expected %h, actual %h", name_q[i], exp_q[i], got);
            passed = 1'b0;
        end
        if (passed) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %-14s %s", name_q[i], passed ? "passed" : "FAILED");
    endtask

    // Ready must never stay high for two cycles in a row
    always @(negedge vdp_clk) begin
        if (vdp_reset) begin
            ready_prev <= 1'b0;
        end else begin
            if (cpu_mem_ready && ready_prev) begin
                $display("Ready stayed high for two cycles in a row");
                other_errors++;
            end
            ready_prev <= cpu_mem_ready;
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge vdp_clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        vdp_reset = 1'b1;
        cpu_mem_valid = 1'b0;
        cpu_address = '0;
        cpu_write_data = '0;
        cpu_wstrb = '0;
        btn_1 = 1'b0;
        btn_2 = 1'b0;
        btn_3 = 1'b0;
        flash_io_in = '0;
        load_trace();
        cycle_limit = 40 * name_q.size() + 16;
        if (trace_ok) begin
            repeat (16) @(negedge vdp_clk);
            vdp_reset = 1'b0;
            @(negedge vdp_clk);
            if (cpu_mem_ready !== 1'b0) begin
                $display("Ready is not low after reset");
                other_errors++;
            end
            for (int i = 0; i < name_q.size(); i++) begin
                run_test(i);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d other errors",
            pass_count + fail_count, pass_count, fail_count, other_errors);
        if (fail_count == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* verif/periph_trace.txt */
# name op address data btn flash_in expected, all values hex, btn is {btn_3,btn_2,btn_1}
# pins expected is {led_r, led_b, flash_csn, flash_clk, flash_io_oe[3:0], flash_io_out[3:0]}
reset_pins pins 000000 00000000 0 0 00000a00
status_write write 000000 00000002 0 0 00000000
status_pins pins 000000 00000000 0 0 00000600
mult_a write 010000 0000fffd 0 0 00000000
mult_b write 010004 00000007 0 0 00000000
mult_read read 010000 00000000 0 0 ffffffeb
mult_a2 write 010000 00008000 0 0 00000000
mult_b2 write 010004 00008000 0 0 00000000
mult_read2 read 010004 00000000 0 0 40000000
pad_latch_on write 020000 00000001 7 0 00000000
pad_latch_off write 020000 00000000 7 0 00000000
pad_bit_00 read 020000 00000000 7 0 00000001
pad_rise_01 write 020000 00000002 7 0 00000000
pad_fall_01 write 020000 00000000 7 0 00000000
pad_bit_01 read 020000 00000000 7 0 00000000
pad_rise_02 write 020000 00000002 7 0 00000000
pad_fall_02 write 020000 00000000 7 0 00000000
pad_rise_03 write 020000 00000002 7 0 00000000
pad_fall_03 write 020000 00000000 7 0 00000000
pad_rise_04 write 020000 00000002 7 0 00000000
pad_fall_04 write 020000 00000000 7 0 00000000
pad_rise_05 write 020000 00000002 7 0 00000000
pad_fall_05 write 020000 00000000 7 0 00000000
pad_rise_06 write 020000 00000002 7 0 00000000
pad_fall_06 write 020000 00000000 7 0 00000000
pad_rise_07 write 020000 00000002 7 0 00000000
pad_fall_07 write 020000 00000000 7 0 00000000
pad_rise_08 write 020000 00000002 7 0 00000000
pad_fall_08 write 020000 00000000 7 0 00000000
pad_rise_09 write 020000 00000002 7 0 00000000
pad_fall_09 write 020000 00000000 7 0 00000000
pad_rise_10 write 020000 00000002 7 0 00000000
pad_fall_10 write 020000 00000000 7 0 00000000
pad_rise_11 write 020000 00000002 7 0 00000000
pad_fall_11 write 020000 00000000 7 0 00000000
pad_rise_12 write 020000 00000002 7 0 00000000
pad_fall_12 write 020000 00000000 7 0 00000000
pad_rise_13 write 020000 00000002 7 0 00000000
pad_fall_13 write 020000 00000000 7 0 00000000
pad_rise_14 write 020000 00000002 7 0 00000000
pad_fall_14 write 020000 00000000 7 0 00000000
pad_bit_14 read 020000 00000000 7 0 00000001
pad_rise_15 write 020000 00000002 7 0 00000000
pad_fall_15 write 020000 00000000 7 0 00000000
pad_bit_15 read 020000 00000000 7 0 00000001
flash_idle write 030000 000003f5 0 0 00000000
flash_idle_pins pins 000000 00000000 0 0 00000600
flash_active write 030000 000081f5 0 0 00000000
flash_active_pins pins 000000 00000000 0 0 000005f5
flash_read read 030000 00000000 0 a 0000000a
unmapped_write write 0f0000 ffffffff 0 0 00000000
unmapped_pins pins 000000 00000000 0 0 000005f5
unmapped_read read 0f0000 00000000 0 0 00000000

/* build.f */
common/periph_pkg.sv
common/periph_bus_if.sv
hdl/periph_decoder.sv
hdl/dsp_mult.sv
hdl/pad_reader.sv
hdl/io_ctrl_regs.sv
hdl/periph_readback.sv
hdl/periph_top.sv
verif/periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the peripheral testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module periph_tb \
    -Mdir obj_dir -o periph_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/periph_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
else
    echo "Simulation reported failures"
    exit 1
fi
